/* source/router_pkg.sv */
package router_pkg;

   // router geometry
   localparam int NUM_PORTS  = 5;
   localparam int PORT_IDX_W = 3;   // wide enough to index NUM_PORTS

   // flit format
   localparam int FLIT_W     = 16;
   localparam int COORD_W    = 2;   // up to a 4x4 mesh
   localparam int PAYLOAD_W  = 12;

   // input buffering
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

   // port numbering, also the bit order of every port_vec_t
   typedef enum logic [PORT_IDX_W-1:0] {
      PORT_N = 3'd0,
      PORT_S = 3'd1,
      PORT_W = 3'd2,
      PORT_E = 3'd3,
      PORT_L = 3'd4
   } port_e;

   // one bit per port, used for requests and grants
   typedef logic [NUM_PORTS-1:0] port_vec_t;

   // single-flit packet
   typedef struct packed {
      logic [COORD_W-1:0]   dest_x;
      logic [COORD_W-1:0]   dest_y;
      logic [PAYLOAD_W-1:0] payload;
   } flit_t;

endpackage

/* source/input_port.sv */
`timescale 1ns/1ps

module input_port #(
   parameter logic [router_pkg::COORD_W-1:0] LOCAL_X = '0,
   parameter logic [router_pkg::COORD_W-1:0] LOCAL_Y = '0
) (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  router_pkg::flit_t     flit_i,
   input  logic                  valid_i,
   output logic                  ready_o,
   input  logic                  grant_i,
   output router_pkg::port_vec_t req_o,
   output router_pkg::flit_t     head_o
);

   router_pkg::flit_t                 mem [router_pkg::FIFO_DEPTH];
   logic [router_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
   logic [router_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
   logic [router_pkg::FIFO_CNT_W-1:0] count_q;
   logic                              wr_en;
   logic                              rd_en;

   assign ready_o = (count_q != router_pkg::FIFO_DEPTH);
   assign wr_en   = valid_i && ready_o;
   assign rd_en   = grant_i;   // head left through the crossbar
   assign head_o  = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= flit_i;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: ;   // idle or push and pop together
         endcase
      end
   end

   // XY routing, x first then y
   always_comb begin
      req_o = '0;
      if (count_q != '0) begin
         if (head_o.dest_x > LOCAL_X) begin
            req_o[router_pkg::PORT_E] = 1'b1;
         end else if (head_o.dest_x < LOCAL_X) begin
            req_o[router_pkg::PORT_W] = 1'b1;
         end else if (head_o.dest_y > LOCAL_Y) begin
            req_o[router_pkg::PORT_N] = 1'b1;
         end else if (head_o.dest_y < LOCAL_Y) begin
            req_o[router_pkg::PORT_S] = 1'b1;
         end else begin
            req_o[router_pkg::PORT_L] = 1'b1;   // arrived
         end
      end
   end

   // a sender refused by a full buffer keeps its flit waiting
   a_full_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_i && !ready_o |=> valid_i && $stable(flit_i));

   // arbiters only see a request while something is buffered
   a_grant_not_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      grant_i |-> count_q != '0);

endmodule

/* source/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  router_pkg::port_vec_t req_i,
   input  logic                  enable_i,
   output router_pkg::port_vec_t grant_o
);

   logic [router_pkg::PORT_IDX_W-1:0] ptr_q;     // highest priority this cycle
   logic [router_pkg::PORT_IDX_W-1:0] win_idx;

   // scan from the pointer, first requester wins
   always_comb begin
      int   idx;
      logic found;
      grant_o = '0;
      win_idx = '0;
      found   = 1'b0;
      for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
         idx = (int'(ptr_q) + i) % router_pkg::NUM_PORTS;
         if (enable_i && !found && req_i[idx]) begin
            grant_o[idx] = 1'b1;
            win_idx      = idx[router_pkg::PORT_IDX_W-1:0];
            found        = 1'b1;
         end
      end
   end

   // winner drops to lowest priority
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ptr_q <= '0;
      end else if (|grant_o) begin
         if (int'(win_idx) == router_pkg::NUM_PORTS - 1) begin
            ptr_q <= '0;
         end else begin
            ptr_q <= win_idx + 1'b1;
         end
      end
   end

   // a winner cannot win again next cycle while another input waits
   genvar k;
   generate
      for (k = 0; k < router_pkg::NUM_PORTS; k++) begin : g_rot
         a_rotate: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            grant_o[k] |=> !(grant_o[k] && ((req_i & ~grant_o) != '0)));
      end
   endgenerate

endmodule

/* source/crossbar_switch_inner.sv */
`timescale 1ns/1ps

module crossbar_switch_inner (
   input  router_pkg::flit_t     in_flit_i  [router_pkg::NUM_PORTS],
   input  router_pkg::port_vec_t grant_i    [router_pkg::NUM_PORTS],
   output router_pkg::flit_t     out_flit_o [router_pkg::NUM_PORTS],
   output router_pkg::port_vec_t load_o
);

   logic [router_pkg::FLIT_W-1:0] sel_bus [router_pkg::NUM_PORTS];

   // one AND-OR mux per output, select is the arbiter's one-hot grant
   always_comb begin
      for (int q = 0; q < router_pkg::NUM_PORTS; q++) begin
         sel_bus[q] = '0;
         for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            sel_bus[q] = sel_bus[q]
                       | ({router_pkg::FLIT_W{grant_i[q][p]}} & in_flit_i[p]);
         end
      end
   end

   genvar q;
   generate
      for (q = 0; q < router_pkg::NUM_PORTS; q++) begin : g_out
         assign out_flit_o[q] = sel_bus[q];
         assign load_o[q]     = |grant_i[q];   // some input won this output
      end
   endgenerate

endmodule

/* source/output_port.sv */
`timescale 1ns/1ps

module output_port (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  router_pkg::flit_t flit_i,
   input  logic              load_i,
   output logic              space_o,
   output router_pkg::flit_t flit_o,
   output logic              valid_o,
   input  logic              ready_i
);

   router_pkg::flit_t flit_q;
   logic              valid_q;

   // empty, or the held flit leaves this cycle
   assign space_o = !valid_q || ready_i;
   assign valid_o = valid_q;
   assign flit_o  = flit_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= 1'b0;
      end else if (load_i) begin
         valid_q <= 1'b1;   // back-to-back refill, no bubble
      end else if (ready_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_i) flit_q <= flit_i;
   end

   // the arbiter is gated by space_o
   a_load_space: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      load_i |-> space_o);

   // stalled flit is held for the neighbor
   a_hold_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_o && !ready_i |=> valid_o && $stable(flit_o));

endmodule

/* source/mesh_router.sv */
`timescale 1ns/1ps

module mesh_router #(
   parameter logic [router_pkg::COORD_W-1:0] LOCAL_X = '0,
   parameter logic [router_pkg::COORD_W-1:0] LOCAL_Y = '0
) (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  router_pkg::flit_t     in_flit_i   [router_pkg::NUM_PORTS],
   input  router_pkg::port_vec_t in_valid_i,
   output router_pkg::port_vec_t in_ready_o,
   output router_pkg::flit_t     out_flit_o  [router_pkg::NUM_PORTS],
   output router_pkg::port_vec_t out_valid_o,
   input  router_pkg::port_vec_t out_ready_i
);

   router_pkg::port_vec_t req       [router_pkg::NUM_PORTS];   // per input
   router_pkg::flit_t     head      [router_pkg::NUM_PORTS];
   router_pkg::port_vec_t arb_req   [router_pkg::NUM_PORTS];   // per output
   router_pkg::port_vec_t grant     [router_pkg::NUM_PORTS];   // per output
   router_pkg::port_vec_t grant_col [router_pkg::NUM_PORTS];   // per input
   router_pkg::port_vec_t in_grant;
   router_pkg::port_vec_t space;
   router_pkg::port_vec_t load;
   router_pkg::flit_t     xbar_flit [router_pkg::NUM_PORTS];

   // requests regrouped by output, grants regrouped by input
   always_comb begin
      for (int q = 0; q < router_pkg::NUM_PORTS; q++) begin
         for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            arb_req[q][p]   = req[p][q];
            grant_col[p][q] = grant[q][p];
         end
      end
   end

   genvar p;
   generate
      for (p = 0; p < router_pkg::NUM_PORTS; p++) begin : g_port
         assign in_grant[p] = |grant_col[p];

         input_port #(
            .LOCAL_X (LOCAL_X),
            .LOCAL_Y (LOCAL_Y)
         ) input_port_i (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .flit_i   (in_flit_i[p]),
            .valid_i  (in_valid_i[p]),
            .ready_o  (in_ready_o[p]),
            .grant_i  (in_grant[p]),
            .req_o    (req[p]),
            .head_o   (head[p])
         );

         rr_arbiter rr_arbiter_i (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (arb_req[p]),
            .enable_i (space[p]),
            .grant_o  (grant[p])
         );

         output_port output_port_i (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .flit_i   (xbar_flit[p]),
            .load_i   (load[p]),
            .space_o  (space[p]),
            .flit_o   (out_flit_o[p]),
            .valid_o  (out_valid_o[p]),
            .ready_i  (out_ready_i[p])
         );

         // an input wins at most one output per cycle
         a_single_pop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            $onehot0(grant_col[p]));
      end
   endgenerate

   crossbar_switch_inner crossbar_switch_inner_i (
      .in_flit_i  (head),
      .grant_i    (grant),
      .out_flit_o (xbar_flit),
      .load_o     (load)
   );

endmodule

/* sim/mesh_router_tb.sv */
`timescale 1ns/1ps

module mesh_router_tb;

   localparam logic [router_pkg::COORD_W-1:0] LX = 2'd1;
   localparam logic [router_pkg::COORD_W-1:0] LY = 2'd2;
   localparam int N          = router_pkg::NUM_PORTS;
   localparam int LOC        = router_pkg::PORT_L;
   localparam int FLITS_RAND = 64;   // random destinations first
   localparam int FLITS_ALL  = 80;   // the rest is a burst to the local port
   localparam int TOTAL      = N * FLITS_ALL;
   localparam int TIMEOUT    = TOTAL * 20;

   logic                  clk;
   logic                  arst_n;
   router_pkg::flit_t     in_flit  [N];
   router_pkg::port_vec_t in_valid;
   router_pkg::port_vec_t in_ready;
   router_pkg::flit_t     out_flit [N];
   router_pkg::port_vec_t out_valid;
   router_pkg::port_vec_t out_ready;

   // reference queues, one per (input, output) pair at p*N+q
   router_pkg::flit_t exp_mem [N*N][FLITS_ALL];
   int                exp_wr  [N*N];
   int                exp_rd  [N*N];

   int                sent     [N];
   int                out_cnt  [N];
   int                wait_cnt [N];
   logic [N-1:0]      acc;   // input transfer on the coming edge
   logic [N-1:0]      stall_q;
   router_pkg::flit_t stall_flit [N];
   int                delivered;
   bit                burst_on;
   int                cycle_cnt;
   int                err_route;
   int                err_order;
   int                err_stall;
   int                err_fair;
   int                err_misc;
   int                total_err;

   mesh_router #(
      .LOCAL_X (LX),
      .LOCAL_Y (LY)
   ) mesh_router_i (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .in_flit_i   (in_flit),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_flit_o  (out_flit),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // dimension order: x first, then y
   function automatic int xy_route(router_pkg::flit_t f);
      if (f.dest_x > LX) return int'(router_pkg::PORT_E);
      if (f.dest_x < LX) return int'(router_pkg::PORT_W);
      if (f.dest_y > LY) return int'(router_pkg::PORT_N);
      if (f.dest_y < LY) return int'(router_pkg::PORT_S);
      return LOC;
   endfunction

   // payload carries {spare, source, sequence}
   function automatic router_pkg::flit_t make_flit(int src, int seq, bit to_local);
      router_pkg::flit_t f;
      f.dest_x  = to_local ? LX : 2'($urandom_range(3, 0));
      f.dest_y  = to_local ? LY : 2'($urandom_range(3, 0));
      f.payload = {1'($urandom_range(1, 0)), 3'(src), 8'(seq)};
      return f;
   endfunction

   function automatic bit all_sent(int limit);
      for (int p = 0; p < N; p++) begin
         if (sent[p] < limit) return 1'b0;
      end
      return 1'b1;
   endfunction

   function automatic int pending(int p, int q);
      return exp_wr[p*N+q] - exp_rd[p*N+q];
   endfunction

   task automatic drive_cycle(input int limit, input bit to_local);
      @(posedge clk);
      #1;
      for (int p = 0; p < N; p++) begin
         if (in_valid[p] && acc[p]) in_valid[p] = 1'b0;
         if (!in_valid[p] && sent[p] < limit && $urandom_range(9, 0) < 6) begin
            in_flit[p]  = make_flit(p, sent[p], to_local);
            in_valid[p] = 1'b1;
            sent[p]++;
         end
      end
      for (int q = 0; q < N; q++) begin
         out_ready[q] = ($urandom_range(9, 0) < 7);   // about 70 percent
      end
   endtask

   // everything sampled at the falling edge, transfers happen at the next rise
   always @(negedge clk) begin
      router_pkg::flit_t f;
      int                s;
      int                idx;
      int                own;
      int                src_l;
      bit                deliv_l;
      if (arst_n) begin
         for (int q = 0; q < N; q++) begin
            if (stall_q[q] && !out_valid[q]) begin
               $display("output %0d dropped valid while stalled", q);
               err_stall++;
            end else if (stall_q[q] && out_flit[q] != stall_flit[q]) begin
               $display("FAIL stall_hold out %0d: expected %h actual %h",
                        q, stall_flit[q], out_flit[q]);
               err_stall++;
            end
            stall_q[q]    = out_valid[q] && !out_ready[q];
            stall_flit[q] = out_flit[q];
         end

         // fairness uses the model state before this edge's transfers
         if (burst_on) begin
            deliv_l = out_valid[LOC] && out_ready[LOC];
            src_l   = int'(out_flit[LOC].payload[10:8]);
            for (int p = 0; p < N; p++) begin
               own = (out_valid[LOC] && src_l == p) ? 1 : 0;
               if (pending(p, LOC) - own <= 0) begin
                  wait_cnt[p] = 0;   // nothing buffered, not requesting
               end else if (deliv_l && src_l == p) begin
                  wait_cnt[p] = 0;
               end else if (deliv_l) begin
                  wait_cnt[p]++;
                  if (wait_cnt[p] > N - 1) begin
                     $display("FAIL rr_fairness in %0d: expected <= %0d actual %0d",
                              p, N - 1, wait_cnt[p]);
                     err_fair++;
                  end
               end
            end
         end

         for (int p = 0; p < N; p++) begin
            acc[p] = in_valid[p] && in_ready[p];
            if (acc[p]) begin
               idx = p * N + xy_route(in_flit[p]);
               exp_mem[idx][exp_wr[idx]] = in_flit[p];
               exp_wr[idx]++;
            end
         end

         for (int q = 0; q < N; q++) begin
            if (out_valid[q] && out_ready[q]) begin
               f = out_flit[q];
               s = int'(f.payload[10:8]);
               delivered++;
               out_cnt[q]++;
               if (xy_route(f) != q) begin
                  $display("FAIL xy_route dest %0d,%0d: expected %0d actual %0d",
                           f.dest_x, f.dest_y, xy_route(f), q);
                  err_route++;
               end
               if (s >= N) begin
                  $display("output %0d delivered a flit with unknown source tag %0d", q, s);
                  err_misc++;
               end else begin
                  idx = s * N + q;
                  if (exp_rd[idx] == exp_wr[idx]) begin
                     $display("output %0d delivered a flit from input %0d that was not queued",
                              q, s);
                     err_misc++;
                  end else begin
                     if (f != exp_mem[idx][exp_rd[idx]]) begin
                        $display("FAIL order in %0d out %0d: expected %h actual %h",
                                 s, q, exp_mem[idx][exp_rd[idx]], f);
                        err_order++;
                     end
                     exp_rd[idx]++;
                  end
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT) begin
         $display("timeout after %0d cycles with %0d of %0d flits delivered",
                  cycle_cnt, delivered, TOTAL);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h395b));
      arst_n    = 1'b0;
      in_valid  = '0;
      out_ready = '0;
      acc       = '0;
      stall_q   = '0;
      burst_on  = 1'b0;
      for (int p = 0; p < N; p++) begin
         in_flit[p] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;

      @(negedge clk);
      if (out_valid != '0) begin
         $display("FAIL reset_out_valid: expected %b actual %b", 5'b00000, out_valid);
         err_misc++;
      end
      if (in_ready != '1) begin
         $display("FAIL reset_in_ready: expected %b actual %b", 5'b11111, in_ready);
         err_misc++;
      end

      while (!all_sent(FLITS_RAND) || in_valid != '0) drive_cycle(FLITS_RAND, 1'b0);
      while (delivered < N * FLITS_RAND) drive_cycle(FLITS_RAND, 1'b0);

      burst_on = 1'b1;   // every input now aims at the local port
      while (!all_sent(FLITS_ALL) || in_valid != '0) drive_cycle(FLITS_ALL, 1'b1);
      while (delivered < TOTAL) drive_cycle(FLITS_ALL, 1'b1);
      repeat (4) drive_cycle(FLITS_ALL, 1'b1);
      @(negedge clk);

      if (delivered != TOTAL) begin
         $display("FAIL delivered_count: expected %0d actual %0d", TOTAL, delivered);
         err_misc++;
      end
      for (int i = 0; i < N * N; i++) begin
         if (exp_rd[i] != exp_wr[i]) begin
            $display("queue from input %0d to output %0d still holds %0d flits",
                     i / N, i % N, exp_wr[i] - exp_rd[i]);
            err_misc++;
         end
      end
      for (int q = 0; q < N; q++) begin
         if (out_cnt[q] == 0) begin
            $display("output %0d never delivered a flit", q);
            err_misc++;
         end
      end
      if (out_valid != '0) begin
         $display("FAIL idle_out_valid: expected %b actual %b", 5'b00000, out_valid);
         err_misc++;
      end

      total_err = err_route + err_order + err_stall + err_fair + err_misc;
      $display("errors: route %0d, order %0d, stall %0d, fairness %0d, other %0d, total %0d",
               err_route, err_order, err_stall, err_fair, err_misc, total_err);
      if (total_err == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* mesh_router.f */
source/router_pkg.sv
source/input_port.sv
source/rr_arbiter.sv
source/crossbar_switch_inner.sv
source/output_port.sv
source/mesh_router.sv
sim/mesh_router_tb.sv
